// ==== include/l2_consts.svh ====
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////
`define L2_ADDR_W      32   // L1 byte address
`define L2_WORD_W      32   // L1 data word
`define L2_MEM_W       64   // One memory beat, two words

//////////////////////////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////////////////////////
`define L2_WAYS        4
`define L2_SETS        64
`define L2_LINE_WORDS  16   // Words per line
`define L2_BURST       8    // Beats per line fill

// Address split, byte offset bits 1..0 sit below the word select
`define L2_TAG_W       20   // Bits 31..12
`define L2_INDEX_W     6    // Bits 11..6
`define L2_OFFSET_W    4    // Bits 5..2

`endif

// ==== hdl/l2_pkg.sv ====
`include "l2_consts.svh"

package l2_pkg;

  // Request and bus payloads
  typedef logic [`L2_ADDR_W-1:0]   addr_t;
  typedef logic [`L2_WORD_W-1:0]   word_t;
  typedef logic [`L2_MEM_W-1:0]    beat_t;

  // Address fields
  typedef logic [`L2_TAG_W-1:0]    tag_t;
  typedef logic [`L2_INDEX_W-1:0]  index_t;
  typedef logic [`L2_OFFSET_W-1:0] offset_t;

  // Way and burst bookkeeping
  typedef logic [$clog2(`L2_WAYS)-1:0]  way_t;
  typedef logic [$clog2(`L2_BURST)-1:0] beat_cnt_t;
  typedef logic [`L2_WAYS-2:0]          plru_t;    // Tree bits of one set

  // Controller states
  typedef enum logic [1:0] {
    IDLE,     // Waiting for req
    LOOKUP,   // Tag compare result pending
    FILL,     // Collecting memory beats
    ACCESS    // Word read or write into the line
  } ctrl_state_t;

endpackage

// ==== hdl/l2_tag_decode.sv ====
`include "l2_consts.svh"

module l2_tag_decode (
  input  logic             stb,
  input  logic             stb_n,
  input  logic             req,
  input  logic             we,
  input  l2_pkg::addr_t    addr,
  input  l2_pkg::word_t    wdata,
  input  logic             tag_install,
  input  l2_pkg::way_t     way_sel,
  output logic             lookup_valid,
  output logic             hit,
  output l2_pkg::way_t     hit_way,
  output logic             has_invalid,
  output l2_pkg::way_t     invalid_way,
  output logic             req_we,
  output l2_pkg::tag_t     req_tag,
  output l2_pkg::index_t   req_index,
  output l2_pkg::offset_t  req_offset,
  output l2_pkg::word_t    req_wdata
);
  import l2_pkg::*;

  tag_t                              tag_q [`L2_WAYS][`L2_SETS];
  logic [`L2_SETS-1:0][`L2_WAYS-1:0] valid_q;
  logic                              req_q;     // Request captured last edge
  logic [`L2_WAYS-1:0]               vset_w;    // Valid bits of the addressed set
  logic [`L2_WAYS-1:0]               match_w;
  way_t                              match_way;
  way_t                              free_way;

  //////////////////////////////////////////////////////////////////////
  // Request capture and address split
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge stb)
  begin
    if (req)
    begin
      req_we     <= we;
      req_tag    <= addr[`L2_ADDR_W-1 -: `L2_TAG_W];
      req_index  <= addr[`L2_OFFSET_W+2 +: `L2_INDEX_W];
      req_offset <= addr[2 +: `L2_OFFSET_W];   // Skip byte offset
      req_wdata  <= wdata;
    end
  end

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      req_q        <= 1'b0;
      lookup_valid <= 1'b0;
    end
    else
    begin
      req_q        <= req;
      lookup_valid <= req_q;   // One cycle after capture
    end
  end

  // All four ways of the set compared in parallel
  always_comb
  begin
    vset_w = valid_q[req_index];
    for (int w = 0; w < `L2_WAYS; w++)
      match_w[w] = vset_w[w] && (tag_q[w][req_index] == req_tag);
  end

  always_comb
  begin
    match_way = '0;
    free_way  = '0;
    for (int w = 0; w < `L2_WAYS; w++)
      if (match_w[w]) match_way = way_t'(w);
    // Walk downwards so the lowest invalid way wins
    for (int w = `L2_WAYS-1; w >= 0; w--)
      if (!vset_w[w]) free_way = way_t'(w);
  end

  always_ff @(posedge stb)
  begin
    hit         <= |match_w;
    hit_way     <= match_way;
    has_invalid <= ~&vset_w;
    invalid_way <= free_way;
  end

  //////////////////////////////////////////////////////////////////////
  // Tag and valid store
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
      valid_q <= '0;
    else if (tag_install)
      valid_q[req_index][way_sel] <= 1'b1;
  end

  always_ff @(posedge stb)
  begin
    if (tag_install)
      tag_q[way_sel][req_index] <= req_tag;   // Overwrites the evicted tag
  end

  // Install only ever targets a missing tag, so a set never holds it twice
  a_single_match : assert property (@(posedge stb) disable iff (!stb_n)
    req_q |-> $onehot0(match_w));

endmodule

// ==== hdl/l2_plru.sv ====
`include "l2_consts.svh"

module l2_plru (
  input  logic            stb,
  input  logic            stb_n,
  input  l2_pkg::index_t  index,
  input  logic            plru_touch,
  input  l2_pkg::way_t    touch_way,
  output l2_pkg::way_t    victim
);
  import l2_pkg::*;

  plru_t [`L2_SETS-1:0] plru_q;   // Bit 2 root, bit 1 left pair, bit 0 right pair
  plru_t                cur_w;

  assign cur_w = plru_q[index];

  // Victim walk down the tree
  always_comb
  begin
    if (!cur_w[2])
      victim = cur_w[1] ? way_t'(1) : way_t'(0);
    else
      victim = cur_w[0] ? way_t'(3) : way_t'(2);
  end

  // Touched way pushes the tree away from itself
  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
      plru_q <= '0;
    else if (plru_touch)
    begin
      case (touch_way)
        2'd0:    begin plru_q[index][2] <= 1'b1; plru_q[index][1] <= 1'b1; end
        2'd1:    begin plru_q[index][2] <= 1'b1; plru_q[index][1] <= 1'b0; end
        2'd2:    begin plru_q[index][2] <= 1'b0; plru_q[index][0] <= 1'b1; end
        default: begin plru_q[index][2] <= 1'b0; plru_q[index][0] <= 1'b0; end
      endcase
    end
  end

endmodule

// ==== hdl/l2_fill_ctrl.sv ====
`include "l2_consts.svh"

module l2_fill_ctrl (
  input  logic               stb,
  input  logic               stb_n,
  input  logic               req,
  input  logic               lookup_valid,
  input  logic               hit,
  input  l2_pkg::way_t       hit_way,
  input  logic               has_invalid,
  input  l2_pkg::way_t       invalid_way,
  input  l2_pkg::way_t       victim,
  input  l2_pkg::index_t     req_index,
  input  l2_pkg::tag_t       req_tag,
  output logic               stall,
  output logic               mem_req,
  output l2_pkg::addr_t      mem_addr,
  output logic               tag_install,
  output l2_pkg::way_t       way_sel,
  output logic               beat_wr,
  output l2_pkg::beat_cnt_t  beat_idx,
  output logic               access_en,
  output logic               plru_touch,
  input  logic               mem_valid
);
  import l2_pkg::*;

  ctrl_state_t state, state_nx;
  beat_cnt_t   beat_cnt;
  way_t        way_q;       // Hit way or fill target
  logic        acc_q;       // Cycle of done
  logic        miss_w;
  logic        last_beat;

  assign miss_w    = (state == LOOKUP) && lookup_valid && !hit;
  assign last_beat = beat_wr && (beat_cnt == beat_cnt_t'(`L2_BURST-1));

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    state_nx = state;
    case (state)
      IDLE:    if (req) state_nx = LOOKUP;
      LOOKUP:  if (lookup_valid) state_nx = hit ? ACCESS : FILL;
      FILL:    if (last_beat) state_nx = ACCESS;
      default: state_nx = IDLE;   // ACCESS lasts one cycle
    endcase
  end

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      state    <= IDLE;
      beat_cnt <= '0;
      mem_req  <= 1'b0;
      acc_q    <= 1'b0;
    end
    else
    begin
      state   <= state_nx;
      mem_req <= miss_w;            // Single pulse per miss
      acc_q   <= (state == ACCESS);
      if (beat_wr)
        beat_cnt <= beat_cnt + 1'b1;   // Wraps to 0 on the eighth beat
    end
  end

  // Way choice: hit way, else lowest invalid, else PLRU victim
  always_ff @(posedge stb)
  begin
    if ((state == LOOKUP) && lookup_valid)
      way_q <= hit ? hit_way : (has_invalid ? invalid_way : victim);
    if (miss_w)
      mem_addr <= {req_tag, req_index, {(`L2_OFFSET_W+2){1'b0}}};   // Line address
  end

  assign stall       = (state != IDLE) || acc_q;
  assign beat_wr     = (state == FILL) && mem_valid;
  assign beat_idx    = beat_cnt;
  assign tag_install = last_beat;
  assign way_sel     = way_q;
  assign access_en   = (state == ACCESS);
  assign plru_touch  = (state == ACCESS);   // Every access, hit or fill

  a_req_not_stalled : assert property (@(posedge stb) disable iff (!stb_n)
    req |-> !stall);
  a_beat_in_fill : assert property (@(posedge stb) disable iff (!stb_n)
    mem_valid |-> (state == FILL));
  a_burst_complete : assert property (@(posedge stb) disable iff (!stb_n)
    (state != FILL) |-> (beat_cnt == '0));

endmodule

// ==== hdl/l2_data_result.sv ====
`include "l2_consts.svh"

module l2_data_result (
  input  logic               stb,
  input  logic               stb_n,
  input  l2_pkg::way_t       way_sel,
  input  l2_pkg::index_t     req_index,
  input  l2_pkg::offset_t    req_offset,
  input  logic               req_we,
  input  l2_pkg::word_t      req_wdata,
  input  logic               beat_wr,
  input  l2_pkg::beat_cnt_t  beat_idx,
  input  l2_pkg::beat_t      mem_data,
  input  logic               access_en,
  output l2_pkg::word_t      rdata,
  output logic               done
);
  import l2_pkg::*;

  word_t line_q [`L2_WAYS][`L2_SETS][`L2_LINE_WORDS];

  //////////////////////////////////////////////////////////////////////
  // Data array
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge stb)
  begin
    if (beat_wr)
    begin
      // Beat k holds word 2k low, word 2k+1 high
      line_q[way_sel][req_index][{beat_idx, 1'b0}] <= mem_data[`L2_WORD_W-1:0];
      line_q[way_sel][req_index][{beat_idx, 1'b1}] <= mem_data[`L2_MEM_W-1:`L2_WORD_W];
    end
    if (access_en && req_we)
      line_q[way_sel][req_index][req_offset] <= req_wdata;   // L1 write
  end

  // Read result held until the next read
  always_ff @(posedge stb)
  begin
    if (access_en && !req_we)
      rdata <= line_q[way_sel][req_index][req_offset];
  end

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
      done <= 1'b0;
    else
      done <= access_en;   // One cycle after the access
  end

endmodule

// ==== hdl/l2_cache_top.sv ====
module l2_cache_top (
  input  logic           stb,
  input  logic           stb_n,
  input  logic           req,
  input  logic           we,
  input  l2_pkg::addr_t  addr,
  input  l2_pkg::word_t  wdata,
  output logic           stall,
  output logic           done,
  output l2_pkg::word_t  rdata,
  output logic           mem_req,
  output l2_pkg::addr_t  mem_addr,
  input  logic           mem_valid,
  input  l2_pkg::beat_t  mem_data
);

  // Decode to execute
  logic               lookup_valid, hit, has_invalid;
  l2_pkg::way_t       hit_way, invalid_way, victim;
  // Registered request fields
  logic               req_we;
  l2_pkg::tag_t       req_tag;
  l2_pkg::index_t     req_index;
  l2_pkg::offset_t    req_offset;
  l2_pkg::word_t      req_wdata;
  // Execute to decode, PLRU and result
  logic               tag_install, beat_wr, access_en, plru_touch;
  l2_pkg::way_t       way_sel;
  l2_pkg::beat_cnt_t  beat_idx;

  l2_tag_decode u_decode (.stb, .stb_n, .req, .we, .addr, .wdata, .tag_install, .way_sel,
    .lookup_valid, .hit, .hit_way, .has_invalid, .invalid_way,
    .req_we, .req_tag, .req_index, .req_offset, .req_wdata);

  l2_fill_ctrl u_ctrl (.stb, .stb_n, .req, .lookup_valid, .hit, .hit_way, .has_invalid,
    .invalid_way, .victim, .req_index, .req_tag, .stall, .mem_req, .mem_addr,
    .tag_install, .way_sel, .beat_wr, .beat_idx, .access_en, .plru_touch, .mem_valid);

  l2_plru u_plru (.stb, .stb_n, .index(req_index), .plru_touch, .touch_way(way_sel),
    .victim);

  l2_data_result u_result (.stb, .stb_n, .way_sel, .req_index, .req_offset, .req_we,
    .req_wdata, .beat_wr, .beat_idx, .mem_data, .access_en, .rdata, .done);

endmodule

// ==== verification/l2_cache_tb.sv ====
`include "l2_consts.svh"

module l2_cache_tb;
  import l2_pkg::*;

  localparam int TIMEOUT = 200;   // Cycles allowed for any single wait

  logic  stb, stb_n, req, we, stall, done, mem_req, mem_valid;
  addr_t addr, mem_addr;
  word_t wdata, rdata;
  beat_t mem_data;

  integer seed   = 74805;   // Beat gap generator
  int     errors = 0;
  int     checks = 0;

  // Reference model state
  logic  ref_valid   [`L2_SETS][`L2_WAYS];
  tag_t  ref_tag     [`L2_SETS][`L2_WAYS];
  plru_t ref_plru    [`L2_SETS];
  word_t ref_written [addr_t];   // L1 writes still held in the cache by word address

  l2_cache_top uut (.stb, .stb_n, .req, .we, .addr, .wdata, .stall, .done, .rdata,
    .mem_req, .mem_addr, .mem_valid, .mem_data);

  initial
  begin
    stb = 1'b0;
    forever #50 stb = ~stb;
  end

  ////////////////////////////////////////////////////////////////////////
  // Memory model returns each word's byte address with bits 1..0 clear
  ////////////////////////////////////////////////////////////////////////
  initial
  begin : mem_model
    addr_t base;
    int    gap;
    forever
    begin
      @(posedge stb);
      #10;
      if (mem_req)
      begin
        base = mem_addr;   // Line address with low bits already zero
        for (int k = 0; k < `L2_BURST; k++)
        begin
          gap = $unsigned($random(seed)) % 4;   // 0 to 3 idle cycles
          repeat (gap)
          begin
            @(posedge stb);
            #10;
          end
          mem_valid = 1'b1;
          mem_data  = {base + addr_t'(8*k+4), base + addr_t'(8*k)};   // Word 2k in low half
          @(posedge stb);
          #10;
          mem_valid = 1'b0;
        end
      end
    end
  end

  // Watchdog in case a wait loop is never reached
  initial
  begin
    repeat (20000) @(posedge stb);
    $display("Simulation ran past the cycle limit without finishing");
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////
  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////
  // Root bit picks the pair and the pair bit picks the way inside it
  function automatic way_t plru_victim(input plru_t p);
    return {p[2], p[2] ? p[0] : p[1]};
  endfunction

  task automatic predict(input logic wr, input addr_t a, input word_t wd,
                         output logic miss, output word_t val);
    index_t ix;
    tag_t   t;
    way_t   w;
    logic   found;
    addr_t  wa;
    ix    = a[11:6];
    t     = a[31:12];
    wa    = {a[31:2], 2'b00};
    miss  = 1'b1;
    found = 1'b0;
    w     = '0;
    for (int i = 0; i < `L2_WAYS; i++)
      if (ref_valid[ix][i] && ref_tag[ix][i] == t)
      begin
        miss = 1'b0;
        w    = way_t'(i);
      end
    if (miss)
    begin
      for (int i = `L2_WAYS-1; i >= 0; i--)   // Lowest invalid way wins
        if (!ref_valid[ix][i])
        begin
          found = 1'b1;
          w     = way_t'(i);
        end
      if (!found)
      begin
        w = plru_victim(ref_plru[ix]);
        for (int j = 0; j < `L2_LINE_WORDS; j++)   // Writes of the evicted line are lost
          ref_written.delete({ref_tag[ix][w], ix, 6'b0} + addr_t'(4*j));
      end
      ref_valid[ix][w] = 1'b1;
      ref_tag[ix][w]   = t;
    end
    // Touch points the tree away from the used way
    ref_plru[ix][2] = ~w[1];
    if (w[1])
      ref_plru[ix][0] = ~w[0];
    else
      ref_plru[ix][1] = ~w[0];
    if (wr)
      ref_written[wa] = wd;
    val = ref_written.exists(wa) ? ref_written[wa] : wa;
  endtask

  ////////////////////////////////////////////////////////////////////////
  // One L1 request driven and checked
  ////////////////////////////////////////////////////////////////////////
  task automatic cache_access(input logic wr, input addr_t a, input word_t wd);
    logic  exp_miss;
    word_t exp_word;
    int    n;
    int    reqs;
    int    stall_low;   // Cycles with stall not high while the request is open
    addr_t seen_addr;
    predict(wr, a, wd, exp_miss, exp_word);
    n = 0;
    while (stall && n < TIMEOUT)
    begin
      @(posedge stb);
      #10;
      n++;
    end
    if (stall)
    begin
      errors++;
      $display("Timed out waiting for stall to drop before access to %h", a);
      return;
    end
    req   = 1'b1;
    we    = wr;
    addr  = a;
    wdata = wd;
    @(posedge stb);   // req sampled here
    #10;
    req       = 1'b0;
    we        = 1'b0;
    n         = 0;
    reqs      = 0;
    stall_low = 0;
    seen_addr = '0;
    if (stall !== 1'b1)
      stall_low++;
    while (!done && n < TIMEOUT)
    begin
      @(posedge stb);
      #10;
      n++;
      if (stall !== 1'b1)
        stall_low++;
      if (mem_req)
      begin
        reqs++;
        seen_addr = mem_addr;
      end
    end
    if (!done)
    begin
      errors++;
      $display("Timed out waiting for done on access to %h", a);
      return;
    end
    check_flag("stall high until done", stall_low == 0, 1'b1);
    check_flag("mem_req issued", reqs != 0, exp_miss);
    check_flag("at most one mem_req", reqs <= 1, 1'b1);
    if (exp_miss)
      check_addr("mem_addr", seen_addr, {a[31:6], 6'b0});
    else
      check_flag("done 3 cycles after req", n == 3, 1'b1);   // Fixed hit latency
    if (!wr)
      check_word("rdata", rdata, exp_word);
    @(posedge stb);
    #10;
    check_flag("stall low after done", stall, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////
  task automatic test_reset_idle();
    for (int i = 0; i < 4; i++)
    begin
      check_flag("stall low after reset", stall, 1'b0);
      check_flag("done low after reset", done, 1'b0);
      check_flag("mem_req low after reset", mem_req, 1'b0);
      @(posedge stb);
      #10;
    end
  endtask

  task automatic test_read_miss_hit();
    cache_access(1'b0, 32'h0000_3A48, '0);   // Fresh line in set 0x29
    cache_access(1'b0, 32'h0000_3A40, '0);   // Same line at word 0
    cache_access(1'b0, 32'h0000_3A7C, '0);   // Last word of the line
  endtask

  task automatic test_write_hit();
    cache_access(1'b1, 32'h0000_3A50, 32'hCAFE_0123);
    cache_access(1'b0, 32'h0000_3A50, '0);
    cache_access(1'b0, 32'h0000_3A54, '0);   // Neighbour keeps memory value
  endtask

  task automatic test_write_miss();
    cache_access(1'b1, 32'h0042_71C8, 32'h5A5A_A5A5);   // Allocates then writes
    cache_access(1'b0, 32'h0042_71C8, '0);
    cache_access(1'b0, 32'h0042_71C0, '0);
  endtask

  task automatic test_eviction();
    addr_t a [5];
    for (int i = 0; i < 5; i++)
    begin
      a[i] = {20'h01000 + 20'(i), 6'd9, 4'(i), 2'b00};   // Five tags in set 9
      cache_access(1'b0, a[i], '0);
    end
    // Survivors first and the victim of the fifth fill last
    for (int i = 1; i <= 4; i++)
      cache_access(1'b0, a[i % 4], '0);
  endtask

  initial
  begin
    stb_n     = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    mem_valid = 1'b0;
    mem_data  = '0;
    for (int s = 0; s < `L2_SETS; s++)
    begin
      ref_plru[s] = '0;
      for (int w = 0; w < `L2_WAYS; w++)
        ref_valid[s][w] = 1'b0;
    end
    repeat (5) @(posedge stb);
    #10;
    stb_n = 1'b1;
    test_reset_idle();
    test_read_miss_hit();
    test_write_hit();
    test_write_miss();
    test_eviction();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
hdl/l2_pkg.sv
hdl/l2_tag_decode.sv
hdl/l2_plru.sv
hdl/l2_fill_ctrl.sv
hdl/l2_data_result.sv
hdl/l2_cache_top.sv
verification/l2_cache_tb.sv

// ==== Makefile ====
# Verilator flow for the L2 cache testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f list.f --top-module l2_cache_tb -Mdir obj_dir -o l2_sim
	./obj_dir/l2_sim | tee $(LOG)
	grep -qxF "** PASS **" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
